//--- common/cpu_pkg.sv
// cpu shared types
package cpu_pkg;

  localparam int DATA_W          = 8;   // datapath width
  localparam int REG_AW          = 2;   // four registers
  localparam int NUM_REGS        = 1 << REG_AW;
  localparam int MEM_DEPTH       = 256; // bytes of data memory
  localparam int IMM_W           = 5;   // immediate / offset / table index
  localparam int JUMP_TABLE_SIZE = 1 << IMM_W;
  localparam int JUMP_SHIFT      = 3;   // table entry i points at address i*8

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [REG_AW-1:0] reg_addr_t;

  // low three bits of the alu group double as alu_op
  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_OR   = 4'h3,
    OP_XOR  = 4'h4,
    OP_SHL  = 4'h5,  // through sc
    OP_SHR  = 4'h6,  // through sc
    OP_MOV  = 4'h7,  // rd = rs
    OP_LDI  = 4'h8,  // r0 = zext(imm)
    OP_LW   = 4'h9,  // rd = mem[rs]
    OP_SW   = 4'ha,  // mem[rs] = rd
    OP_BZ   = 4'hb,  // pc += sext(imm) if zero
    OP_BNZ  = 4'hc,  // pc += sext(imm) if !zero
    OP_JMP  = 4'hd,  // pc = table[imm]
    OP_CLC  = 4'he,
    OP_HALT = 4'hf
  } opcode_e;

  // register form, bit 8..0
  typedef struct packed {
    opcode_e   op;
    logic      spare;  // unused, keep 0
    reg_addr_t rd;
    reg_addr_t rs;
  } r_fmt_t;

  // immediate form
  typedef struct packed {
    opcode_e          op;
    logic [IMM_W-1:0] imm;
  } i_fmt_t;

  // one 9-bit machine word, two views
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } instr_u;

  typedef struct packed {
    logic       reg_write;
    logic       mem_write;
    logic       mem_to_reg;  // write back from memory
    logic       imm_to_reg;  // write back immediate (ldi)
    logic [2:0] alu_op;
    logic       flag_en;     // zero/parity (and sc per op) update
    logic       sc_clr;
    logic       rel_jump;    // branch taken, already resolved
    logic       abs_jump;
  } ctrl_t;

  typedef struct packed {
    logic zero;
    logic parity;
    logic sc;  // shift/carry
  } flags_t;

endpackage

//--- hw/alu_unit.sv
// alu with registered flags
module alu_unit (
  input  logic            clk,
  input  logic            rst_n,
  input  cpu_pkg::ctrl_t  ctrl,
  input  cpu_pkg::data_t  in_a,   // reg[rd]
  input  cpu_pkg::data_t  in_b,   // reg[rs]
  output cpu_pkg::data_t  rslt,
  output cpu_pkg::flags_t flags
);
  import cpu_pkg::*;

  opcode_e op;
  logic    sc_nxt;  // next shift/carry

  // alu group sits in the lower half of the opcode map
  assign op = opcode_e'({1'b0, ctrl.alu_op});

  always_comb begin
    sc_nxt = flags.sc;  // logic ops leave sc alone
    rslt   = in_a;
    case (op)
      OP_ADD: {sc_nxt, rslt} = {1'b0, in_a} + {1'b0, in_b};          // carry out
      OP_SUB: {sc_nxt, rslt} = {1'b0, in_a} + {1'b0, ~in_b} + 9'd1;  // sc = no borrow
      OP_AND: rslt = in_a & in_b;
      OP_OR:  rslt = in_a | in_b;
      OP_XOR: rslt = in_a ^ in_b;
      OP_SHL: {sc_nxt, rslt} = {in_a, flags.sc};  // msb out, sc in at lsb
      OP_SHR: {rslt, sc_nxt} = {flags.sc, in_a};  // lsb out, sc in at msb
      OP_MOV: rslt = in_b;
      default: rslt = in_a;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags <= '0;
    end else begin
      if (ctrl.flag_en) begin
        flags.zero   <= (rslt == '0);
        flags.parity <= ^rslt;  // odd parity of result
        flags.sc     <= sc_nxt;
      end
      if (ctrl.sc_clr) begin
        flags.sc <= 1'b0;
      end
    end
  end

endmodule

//--- hw/control.sv
// run state and instruction decode
module control (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            req,    // start pulse
  input  cpu_pkg::instr_u instr,
  input  cpu_pkg::flags_t flags,  // registered alu flags
  output cpu_pkg::ctrl_t  ctrl,
  output logic            pc_clr,
  output logic            pc_en,
  output logic            run,
  output logic            done
);
  import cpu_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_RUN,
    S_HALT
  } state_t;

  state_t  state;
  opcode_e op;
  logic    start;    // accepted req

  assign op    = instr.r_fmt.op;
  assign run   = (state == S_RUN);
  assign done  = (state == S_HALT);
  assign start = req && !run;  // req while running is dropped

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE, S_HALT: if (start) state <= S_RUN;
        S_RUN:          if (op == OP_HALT) state <= S_HALT;
        default:        state <= S_IDLE;
      endcase
    end
  end

  assign pc_clr = start;
  assign pc_en  = run && (op != OP_HALT);  // pc freezes on halt

  // decode, everything zero outside run
  always_comb begin
    ctrl = '0;
    if (run) begin
      case (op)
        OP_ADD, OP_SUB, OP_AND, OP_OR,
        OP_XOR, OP_SHL, OP_SHR, OP_MOV: begin
          ctrl.reg_write = 1'b1;
          ctrl.alu_op    = op[2:0];
          ctrl.flag_en   = 1'b1;
        end
        OP_LDI: begin
          ctrl.reg_write  = 1'b1;
          ctrl.imm_to_reg = 1'b1;  // always into r0
        end
        OP_LW: begin
          ctrl.reg_write  = 1'b1;
          ctrl.mem_to_reg = 1'b1;
        end
        OP_SW:   ctrl.mem_write = 1'b1;
        OP_BZ:   ctrl.rel_jump  = flags.zero;
        OP_BNZ:  ctrl.rel_jump  = !flags.zero;
        OP_JMP:  ctrl.abs_jump  = 1'b1;
        OP_CLC:  ctrl.sc_clr    = 1'b1;
        default: ctrl = '0;  // halt does nothing here
      endcase
    end
  end

endmodule

//--- hw/cpu_top.sv
// single-cycle cpu top level
module cpu_top #(
  parameter int D = 8  // pc width
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           req,
  output logic           done,
  input  logic           host_wr_en,
  input  cpu_pkg::data_t host_addr,
  input  cpu_pkg::data_t host_wdata,
  output cpu_pkg::data_t host_rdata
);
  import cpu_pkg::*;

  instr_u    instr;
  ctrl_t     ctrl;
  flags_t    flags;
  logic      pc_clr;
  logic      pc_en;
  logic      run;
  reg_addr_t wr_addr;
  data_t     dat_a;     // reg[rd]
  data_t     dat_b;     // reg[rs]
  data_t     alu_rslt;
  data_t     mem_rdata;
  data_t     wb_data;

  fetch_unit #(.D(D)) fetch_unit_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .pc_clr (pc_clr),
    .pc_en  (pc_en),
    .ctrl   (ctrl),
    .imm    (instr.i_fmt.imm),
    .instr  (instr)
  );

  control control_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (req),
    .instr  (instr),
    .flags  (flags),
    .ctrl   (ctrl),
    .pc_clr (pc_clr),
    .pc_en  (pc_en),
    .run    (run),
    .done   (done)
  );

  // ldi always targets r0
  assign wr_addr = ctrl.imm_to_reg ? reg_addr_t'(0) : instr.r_fmt.rd;

  // write-back source select
  always_comb begin
    if (ctrl.imm_to_reg) begin
      wb_data = data_t'(instr.i_fmt.imm);  // zero-extended
    end else if (ctrl.mem_to_reg) begin
      wb_data = mem_rdata;
    end else begin
      wb_data = alu_rslt;
    end
  end

  reg_file reg_file_i (
    .clk       (clk),
    .wr_en     (ctrl.reg_write),
    .rd_addr_a (instr.r_fmt.rd),
    .rd_addr_b (instr.r_fmt.rs),
    .wr_addr   (wr_addr),
    .wr_data   (wb_data),
    .dat_a     (dat_a),
    .dat_b     (dat_b)
  );

  alu_unit alu_unit_i (
    .clk   (clk),
    .rst_n (rst_n),
    .ctrl  (ctrl),
    .in_a  (dat_a),
    .in_b  (dat_b),
    .rslt  (alu_rslt),
    .flags (flags)
  );

  // address from rs, store data from rd
  dat_mem dat_mem_i (
    .clk        (clk),
    .run        (run),
    .core_we    (ctrl.mem_write),
    .core_addr  (dat_b),
    .core_wdata (dat_a),
    .host_we    (host_wr_en),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .rdata      (mem_rdata)
  );

  assign host_rdata = mem_rdata;  // meaningful only while idle

endmodule

//--- hw/dat_mem.sv
// data memory with host port
module dat_mem (
  input  logic           clk,
  input  logic           run,         // selects core port
  input  logic           core_we,
  input  cpu_pkg::data_t core_addr,
  input  cpu_pkg::data_t core_wdata,
  input  logic           host_we,
  input  cpu_pkg::data_t host_addr,
  input  cpu_pkg::data_t host_wdata,
  output cpu_pkg::data_t rdata
);
  import cpu_pkg::*;

  data_t mem [MEM_DEPTH];
  data_t addr;
  data_t wdata;
  logic  we;

  // host is shut out while the core runs
  assign addr  = run ? core_addr  : host_addr;
  assign wdata = run ? core_wdata : host_wdata;
  assign we    = run ? core_we    : host_we;

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  assign rdata = mem[addr];  // async read

endmodule

//--- hw/fetch_unit.sv
// program counter and instruction rom
module fetch_unit #(
  parameter int D = 8  // pc width
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      pc_clr,  // start of run
  input  logic                      pc_en,
  input  cpu_pkg::ctrl_t            ctrl,
  input  logic [cpu_pkg::IMM_W-1:0] imm,
  output cpu_pkg::instr_u           instr
);
  import cpu_pkg::*;

  logic [D-1:0] pc;
  logic [D-1:0] rel_off;                    // sign-extended branch offset
  logic [D-1:0] jump_tbl [JUMP_TABLE_SIZE]; // absolute targets
  logic [8:0]   rom      [2**D];            // machine code

  initial begin
    $readmemb("prog.mem", rom);
  end

  // fixed target table, entry i lands on a block of eight
  always_comb begin
    for (int i = 0; i < JUMP_TABLE_SIZE; i++) begin
      jump_tbl[i] = D'(i) << JUMP_SHIFT;
    end
  end

  assign rel_off = {{(D-IMM_W){imm[IMM_W-1]}}, imm};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (pc_clr) begin
      pc <= '0;                  // req restarts at 0
    end else if (pc_en) begin
      if (ctrl.rel_jump) begin
        pc <= pc + rel_off;      // offset relative to branch itself
      end else if (ctrl.abs_jump) begin
        pc <= jump_tbl[imm];
      end else begin
        pc <= pc + D'(1);
      end
    end
  end

  assign instr = rom[pc];  // async read

endmodule

//--- hw/reg_file.sv
// four-entry register file
module reg_file (
  input  logic               clk,
  input  logic               wr_en,
  input  cpu_pkg::reg_addr_t rd_addr_a,
  input  cpu_pkg::reg_addr_t rd_addr_b,
  input  cpu_pkg::reg_addr_t wr_addr,
  input  cpu_pkg::data_t     wr_data,
  output cpu_pkg::data_t     dat_a,
  output cpu_pkg::data_t     dat_b
);
  import cpu_pkg::*;

  data_t regs [NUM_REGS];  // contents undefined until written

  always_ff @(posedge clk) begin
    if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // both reads async
  assign dat_a = regs[rd_addr_a];
  assign dat_b = regs[rd_addr_b];

endmodule

//--- prog.mem
// test program, one 9-bit word per line
// columns: opcode[8:5] then spare,rd,rs or imm[4:0]
100000000
011100100
100101001
100000001
011100100
100101101
000001011
010101111
110100010
@10
100010000
011100100
101001001
100000001
011100100
100000011
011101000
011001111
000101001
110011110
111000000
010101111
100000000
011101000
101100010
011101101
100000010
011100100
100101001
001001011
001101001
100010010
011100100
101001001
100010011
011100100
101001101
111100000

//--- run.sh
#!/bin/sh
# build and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_cpu -f tb.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "PASS: all tests" sim.log; then
  exit 0
fi
echo "simulation did not pass"
exit 1

//--- tb.f
common/cpu_pkg.sv
hw/fetch_unit.sv
hw/control.sv
hw/alu_unit.sv
hw/reg_file.sv
hw/dat_mem.sv
hw/cpu_top.sv
testbench/cpu_assert.sv
testbench/tb_cpu.sv

//--- testbench/cpu_assert.sv
// run state checks
module cpu_assert (
  input logic clk,
  input logic rst_n,
  input logic req,
  input logic run,
  input logic done,
  input logic pc_clr
);
  timeunit 1ns;
  timeprecision 1ps;

  // halted and running are exclusive
  assert property (@(posedge clk) disable iff (!rst_n) !(done && run))
    else $error("done and run high together");

  assert property (@(posedge clk) $rose(rst_n) |-> !done)
    else $error("done high right after reset");

  // a run only starts from a req that cleared the pc
  assert property (@(posedge clk) disable iff (!rst_n)
                   $rose(run) |-> ($past(req) && $past(pc_clr)))
    else $error("run entered without an accepted req");

  assert property (@(posedge clk) disable iff (!rst_n) pc_clr |=> run)
    else $error("run not entered after pc_clr");

endmodule

bind control cpu_assert cpu_assert_i (
  .clk    (clk),
  .rst_n  (rst_n),
  .req    (req),
  .run    (run),
  .done   (done),
  .pc_clr (pc_clr)
);

//--- testbench/tb_cpu.sv
// cpu testbench
module tb_cpu;
  timeunit 1ns;
  timeprecision 1ps;
  import cpu_pkg::*;

  localparam int  NUM_RUNS = 2;
  localparam time TIMEOUT  = NUM_RUNS * 2000 * 20ns;  // per-run budget

  logic  clk;
  logic  rst_n;
  logic  req;
  logic  done;
  logic  host_wr_en;
  data_t host_addr;
  data_t host_wdata;
  data_t host_rdata;

  logic [8:0] prog     [256];        // same image as the rom
  data_t      init_mem [MEM_DEPTH];  // memory before a run
  data_t      exp_mem  [MEM_DEPTH];  // model result
  int         data_errs;
  int         done_errs;
  int         count_errs;

  cpu_top #(.D(8)) cpu_top_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .done       (done),
    .host_wr_en (host_wr_en),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(TIMEOUT);
    $display("timeout: the DUT never finished, run stopped at %0t", $time);
    $display("FAIL: see errors above");
    $finish;
  end

  // isa interpreter over exp_mem, returns instructions executed
  function automatic int isa_model();
    data_t   r [NUM_REGS];
    flags_t  f;
    instr_u  iw;
    opcode_e op;
    data_t   a;
    data_t   b;
    data_t   res;
    logic [8:0] sum;
    logic [7:0] pc;
    logic [7:0] pc_nxt;
    int      n;
    exp_mem = init_mem;
    r = '{default: '0};
    f = '0;
    pc = '0;
    n = 0;
    while (n < 5000) begin
      iw = instr_u'(prog[pc]);
      op = iw.r_fmt.op;
      a = r[iw.r_fmt.rd];
      b = r[iw.r_fmt.rs];
      res = a;
      pc_nxt = pc + 8'd1;
      n++;
      case (op)
        OP_ADD: begin
          sum = {1'b0, a} + {1'b0, b};
          res = sum[7:0];
          f.sc = sum[8];
        end
        OP_SUB: begin
          res = a - b;
          f.sc = (a >= b);  // no borrow
        end
        OP_AND: res = a & b;
        OP_OR:  res = a | b;
        OP_XOR: res = a ^ b;
        OP_SHL: begin
          res = {a[6:0], f.sc};
          f.sc = a[7];
        end
        OP_SHR: begin
          res = {f.sc, a[7:1]};
          f.sc = a[0];
        end
        OP_MOV: res = b;
        OP_LDI: r[0] = {3'b000, iw.i_fmt.imm};
        OP_LW:  r[iw.r_fmt.rd] = exp_mem[b];
        OP_SW:  exp_mem[b] = a;
        OP_BZ:  if (f.zero) pc_nxt = pc + {{3{iw.i_fmt.imm[4]}}, iw.i_fmt.imm};
        OP_BNZ: if (!f.zero) pc_nxt = pc + {{3{iw.i_fmt.imm[4]}}, iw.i_fmt.imm};
        OP_JMP: pc_nxt = {iw.i_fmt.imm, 3'b000};
        OP_CLC: f.sc = 1'b0;
        default: return n;  // halt
      endcase
      if (!op[3]) begin  // alu group writes rd and flags
        r[iw.r_fmt.rd] = res;
        f.zero = (res == '0);
        f.parity = ^res;
      end
      pc = pc_nxt;
    end
    return n;
  endfunction

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      data_errs++;
      $display("[FAIL] %s: expected %02h, actual %02h", name, exp, act);
    end
  endtask

  task automatic check_done(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      done_errs++;
      $display("[FAIL] %s: expected done %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      count_errs++;
      $display("[FAIL] %s: expected %0d cycles, actual %0d", name, exp, act);
    end
  endtask

  // caller drops host_wr_en after the last write
  task automatic host_write(input data_t a, input data_t d);
    @(negedge clk);
    host_wr_en = 1'b1;
    host_addr  = a;
    host_wdata = d;
  endtask

  task automatic host_read(input data_t a, output data_t d);
    @(negedge clk);
    host_addr = a;
    #1 d = host_rdata;  // async read settles
  endtask

  task automatic run_program(input string tag, input bit intrude);
    int    exp_n;
    int    cycles;
    data_t rd;
    for (int i = 0; i < MEM_DEPTH; i++) begin
      init_mem[i] = data_t'($urandom);
      host_write(data_t'(i), init_mem[i]);
    end
    @(negedge clk);
    host_wr_en = 1'b0;
    req = 1'b1;
    exp_n = isa_model();
    @(negedge clk);
    req = 1'b0;
    check_done({tag, "_start"}, 1'b0, done);
    cycles = 0;
    while (!done) begin
      host_wr_en = intrude && (cycles < 8);  // should be ignored
      host_addr  = data_t'($urandom);
      host_wdata = data_t'($urandom);
      @(negedge clk);
      cycles++;
    end
    host_wr_en = 1'b0;
    check_count({tag, "_cycles"}, exp_n, cycles);
    for (int i = 0; i < MEM_DEPTH; i++) begin
      host_read(data_t'(i), rd);
      check_data($sformatf("%s mem[%0d]", tag, i), exp_mem[i], rd);
    end
  endtask

  initial begin
    data_t shadow [MEM_DEPTH];
    data_t addrs  [16];
    data_t rd;
    void'($urandom(32'h00035536));
    $readmemb("prog.mem", prog);
    data_errs  = 0;
    done_errs  = 0;
    count_errs = 0;
    rst_n      = 1'b0;
    req        = 1'b0;
    host_wr_en = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    check_done("reset", 1'b0, done);
    repeat (10) begin
      @(negedge clk);
      check_done("idle", 1'b0, done);
    end
    // host port loopback
    for (int i = 0; i < 16; i++) begin
      addrs[i] = data_t'($urandom);
      shadow[addrs[i]] = data_t'($urandom);
      host_write(addrs[i], shadow[addrs[i]]);
    end
    @(negedge clk);
    host_wr_en = 1'b0;
    for (int i = 0; i < 16; i++) begin
      host_read(addrs[i], rd);
      check_data($sformatf("host mem[%0d]", addrs[i]), shadow[addrs[i]], rd);
    end
    run_program("run1", 1'b1);
    check_done("done_hold", 1'b1, done);
    run_program("run2", 1'b0);
    $display("errors: data %0d, done %0d, cycles %0d", data_errs, done_errs, count_errs);
    if (data_errs + done_errs + count_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
